// File: hdl/lpif_pkg.sv
// LPIF link layer shared definitions
package lpif_pkg;

  // Word widths
  localparam int LINK_W = 77;
  localparam int PHY_W  = 80;

  // One packed LPIF beat, bit 0 upward:
  // valid, crc_valid, crc[3:0], dvalid, data[63:0], protid[1:0], state[3:0]
  typedef logic [LINK_W-1:0] link_word_t;

  // One AIB PHY transfer
  typedef logic [PHY_W-1:0]  phy_word_t;

  // LPIF field types
  typedef logic [3:0]  lpif_state_t;
  typedef logic [1:0]  lpif_protid_t;
  typedef logic [63:0] lpif_data_t;
  typedef logic [3:0]  lpif_crc_t;

  // Delay count in clk_wr cycles
  typedef logic [15:0] delay_t;

  // Reserved PHY positions
  localparam int PHY_STB_POS   = 1;
  localparam int PHY_SPARE_POS = 39;
  localparam int PHY_MRK_POS   = 79;

  // Payload placement
  // Link bits fill the non-reserved PHY positions in ascending order
  // link[0]     -> phy[0]
  // link[37:1]  -> phy[38:2]
  // link[76:38] -> phy[78:40]

  // Online state per direction
  typedef enum logic [1:0] {SYNC_OFF, SYNC_WAIT, SYNC_ON} sync_state_t;

endpackage

// File: hdl/ll_auto_sync.sv
// Link online delay and strobe generation
`timescale 1ns/1ps

module ll_auto_sync
  import lpif_pkg::*;
#(
  parameter bit PERSISTENT_MARKER = 1'b1
) (
  input  logic   clk_wr,
  input  logic   rst_n,
  input  logic   tx_online,
  input  logic   rx_online,
  input  logic   tx_mrk_userbit,
  input  logic   tx_stb_userbit,
  input  delay_t delay_x_value,
  input  delay_t delay_y_value,
  input  delay_t delay_z_value,
  output logic   tx_online_delay,
  output logic   rx_online_delay,
  output logic   tx_auto_mrk_userbit,
  output logic   tx_auto_stb_userbit
);

  // Direction index into the per-direction arrays
  localparam int TX = 0;
  localparam int RX = 1;

  logic        [1:0] online_in;
  delay_t            delay_in [2];
  sync_state_t       state_q  [2];
  delay_t            stable_q [2];
  delay_t            per_cnt_q;
  delay_t            per_last;

  assign online_in    = {rx_online, tx_online};
  assign delay_in[TX] = delay_z_value;
  assign delay_in[RX] = delay_x_value;

  //////////////////////////////////////////////////////////////////////
  // Online FSMs
  // Online N edges after the first high sample
  // A zero delay counts as one
  always_ff @(posedge clk_wr) begin
    for (int i = 0; i < 2; i++) begin
      if (!rst_n) begin
        state_q[i]  <= SYNC_OFF;
        stable_q[i] <= '0;
      end else if (!online_in[i]) begin
        // Any low sample drops the link and restarts the count
        state_q[i]  <= SYNC_OFF;
        stable_q[i] <= '0;
      end else begin
        case (state_q[i])
          SYNC_OFF: begin
            state_q[i]  <= SYNC_WAIT;
            stable_q[i] <= 16'd1;
          end
          SYNC_WAIT: begin
            if (stable_q[i] >= delay_in[i]) state_q[i] <= SYNC_ON;
            else stable_q[i] <= stable_q[i] + 16'd1;
          end
          default: state_q[i] <= SYNC_ON;
        endcase
      end
    end
  end

  assign tx_online_delay = (state_q[TX] == SYNC_ON);
  assign rx_online_delay = (state_q[RX] == SYNC_ON);

  //////////////////////////////////////////////////////////////////////
  // Strobe period
  // Zero period behaves as one
  assign per_last = (delay_y_value == '0) ? '0 : delay_y_value - 16'd1;

  always_ff @(posedge clk_wr) begin
    if (!rst_n) per_cnt_q <= '0;
    else if (!tx_online_delay) per_cnt_q <= '0;
    else if (per_cnt_q >= per_last) per_cnt_q <= '0;
    else per_cnt_q <= per_cnt_q + 16'd1;
  end

  // Count zero marks the first online cycle and each period start
  assign tx_auto_stb_userbit = tx_online_delay & ((per_cnt_q == '0) | tx_stb_userbit);

  // Marker gating
  if (PERSISTENT_MARKER) begin : g_mrk_persist
    assign tx_auto_mrk_userbit = tx_online_delay & tx_mrk_userbit;
  end else begin : g_mrk_first
    logic tx_was_online_q;
    always_ff @(posedge clk_wr) begin
      if (!rst_n) tx_was_online_q <= 1'b0;
      else tx_was_online_q <= tx_online_delay;
    end
    // Only the first online cycle
    assign tx_auto_mrk_userbit = tx_online_delay & ~tx_was_online_q;
  end

  // No strobe while the transmit side is offline
  a_stb_online: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_auto_stb_userbit |-> tx_online_delay)
    else $error("strobe raised while transmit side offline");

  // Receive side comes up only on a high rx_online sample
  a_rx_rise: assert property (@(posedge clk_wr) disable iff (!rst_n)
    $rose(rx_online_delay) |-> $past(rx_online))
    else $error("rx_online_delay rose with rx_online low");

endmodule

// File: hdl/lpif_field_map.sv
// LPIF field mapping to and from link words
`timescale 1ns/1ps

module lpif_field_map
  import lpif_pkg::*;
(
  // Upstream LPIF bus
  input  lpif_state_t  ustrm_state,
  input  lpif_protid_t ustrm_protid,
  input  lpif_data_t   ustrm_data,
  input  logic         ustrm_dvalid,
  input  lpif_crc_t    ustrm_crc,
  input  logic         ustrm_crc_valid,
  input  logic         ustrm_valid,
  // Received link word and its gate
  input  link_word_t   rx_link,
  input  logic         rx_online_delay,
  // Link word to PHY side
  output link_word_t   tx_link,
  // Downstream LPIF bus
  output lpif_state_t  dstrm_state,
  output lpif_protid_t dstrm_protid,
  output lpif_data_t   dstrm_data,
  output logic         dstrm_dvalid,
  output lpif_crc_t    dstrm_crc,
  output logic         dstrm_crc_valid,
  output logic         dstrm_valid
);

  link_word_t rx_gated;

  //////////////////////////////////////////////////////////////////////
  // Upstream packing
  // Concatenation runs from state down to valid at bit 0
  assign tx_link = {ustrm_state,
                    ustrm_protid,
                    ustrm_data,
                    ustrm_dvalid,
                    ustrm_crc,
                    ustrm_crc_valid,
                    ustrm_valid};

  //////////////////////////////////////////////////////////////////////
  // Downstream unpacking
  // Whole word zeroed while receive is offline
  assign rx_gated = rx_online_delay ? rx_link : '0;

  // Same order as the packing above
  assign {dstrm_state,
          dstrm_protid,
          dstrm_data,
          dstrm_dvalid,
          dstrm_crc,
          dstrm_crc_valid,
          dstrm_valid} = rx_gated;

  // No downstream beat may leak out before link-up
  always_comb begin
    a_dstrm_gate: assert (!dstrm_valid || rx_online_delay)
      else $error("dstrm_valid high while receive side offline");
  end

endmodule

// File: hdl/lpif_phy_concat.sv
// PHY word assembly and disassembly
`timescale 1ns/1ps

module lpif_phy_concat
  import lpif_pkg::*;
(
  input  logic       clk_wr,
  input  logic       rst_n,
  // Transmit side
  input  link_word_t tx_link,
  input  logic       tx_online,
  input  logic       tx_stb_userbit,
  input  logic       tx_mrk_userbit,
  output phy_word_t  tx_phy0,
  // Receive side
  input  phy_word_t  rx_phy0,
  output link_word_t rx_link
);

  // Link bit ranges on either side of the spare position
  localparam int LO_TOP = PHY_SPARE_POS - 2;
  localparam int HI_BOT = PHY_SPARE_POS - 1;

  phy_word_t tx_word;
  phy_word_t rx_q;

  //////////////////////////////////////////////////////////////////////
  // Transmit assembly
  always_comb begin
    tx_word = '0;
    // Bit 0 sits below the strobe
    tx_word[0] = tx_link[0];
    tx_word[PHY_STB_POS] = tx_stb_userbit;
    // Lower payload run, between strobe and spare
    tx_word[PHY_SPARE_POS-1:PHY_STB_POS+1] = tx_link[LO_TOP:1];
    // Spare stays zero
    tx_word[PHY_SPARE_POS] = 1'b0;
    // Upper payload run, between spare and marker
    tx_word[PHY_MRK_POS-1:PHY_SPARE_POS+1] = tx_link[LINK_W-1:HI_BOT];
    tx_word[PHY_MRK_POS] = tx_mrk_userbit;
  end

  // Output register
  // Idle word is all zeros
  always_ff @(posedge clk_wr) begin
    if (!rst_n) tx_phy0 <= '0;
    else if (!tx_online) tx_phy0 <= '0;
    else tx_phy0 <= tx_word;
  end

  //////////////////////////////////////////////////////////////////////
  // Receive disassembly
  // Input register, data only
  always_ff @(posedge clk_wr) begin
    rx_q <= rx_phy0;
  end

  // Strobe, spare and marker dropped
  assign rx_link = {rx_q[PHY_MRK_POS-1:PHY_SPARE_POS+1],
                    rx_q[PHY_SPARE_POS-1:PHY_STB_POS+1],
                    rx_q[0]};

  // Spare never driven on the wire
  a_spare_zero: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !tx_phy0[PHY_SPARE_POS])
    else $error("spare bit set in tx_phy0");

endmodule

// File: hdl/lpif_link_top.sv
// LPIF over AIB slave link layer
`timescale 1ns/1ps

module lpif_link_top
  import lpif_pkg::*;
#(
  parameter bit PERSISTENT_MARKER = 1'b1
) (
  input  logic         clk_wr,
  input  logic         rst_n,
  // Link control
  input  logic         tx_online,
  input  logic         rx_online,
  input  logic         tx_mrk_userbit,
  input  logic         tx_stb_userbit,
  input  delay_t       delay_x_value,
  input  delay_t       delay_y_value,
  input  delay_t       delay_z_value,
  // PHY
  output phy_word_t    tx_phy0,
  input  phy_word_t    rx_phy0,
  // Upstream LPIF
  input  lpif_state_t  ustrm_state,
  input  lpif_protid_t ustrm_protid,
  input  lpif_data_t   ustrm_data,
  input  logic         ustrm_dvalid,
  input  lpif_crc_t    ustrm_crc,
  input  logic         ustrm_crc_valid,
  input  logic         ustrm_valid,
  // Downstream LPIF
  output lpif_state_t  dstrm_state,
  output lpif_protid_t dstrm_protid,
  output lpif_data_t   dstrm_data,
  output logic         dstrm_dvalid,
  output lpif_crc_t    dstrm_crc,
  output logic         dstrm_crc_valid,
  output logic         dstrm_valid
);

  // Internal links
  link_word_t tx_link;
  link_word_t rx_link;
  logic       tx_online_delay;
  logic       rx_online_delay;
  logic       tx_auto_mrk_userbit;
  logic       tx_auto_stb_userbit;

  //////////////////////////////////////////////////////////////////////
  // Link-up timing
  ll_auto_sync #(
    .PERSISTENT_MARKER (PERSISTENT_MARKER)
  ) ll_auto_sync_i (
    .clk_wr              (clk_wr),
    .rst_n               (rst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_stb_userbit      (tx_stb_userbit),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .delay_z_value       (delay_z_value),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit),
    .tx_auto_stb_userbit (tx_auto_stb_userbit)
  );

  // LPIF fields, receive side gated by link-up
  lpif_field_map lpif_field_map_i (
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .rx_link         (rx_link),
    .rx_online_delay (rx_online_delay),
    .tx_link         (tx_link),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid)
  );

  // PHY word, transmit enabled by the delayed online flag
  lpif_phy_concat lpif_phy_concat_i (
    .clk_wr         (clk_wr),
    .rst_n          (rst_n),
    .tx_link        (tx_link),
    .tx_online      (tx_online_delay),
    .tx_stb_userbit (tx_auto_stb_userbit),
    .tx_mrk_userbit (tx_auto_mrk_userbit),
    .tx_phy0        (tx_phy0),
    .rx_phy0        (rx_phy0),
    .rx_link        (rx_link)
  );

endmodule

// File: testbench/tb_lpif_link.sv
// LPIF link layer testbench
`timescale 1ns/1ps

module tb_lpif_link
  import lpif_pkg::*;
;

  localparam int NROWS      = 10;
  localparam int UP_TIMEOUT = 40;

  // One table row, cycles of zero means wait for link-up
  typedef struct packed {
    logic        tx_on;
    logic        rx_on;
    logic        mrk;
    logic        stb;
    logic [2:0]  rsv;     // forces strobe, spare, marker in rx_phy0
    lpif_state_t state;
    logic [7:0]  cycles;
  } row_t;

  logic clk_wr = 1'b0;
  logic rst_n;
  logic tx_online, rx_online, tx_mrk_userbit, tx_stb_userbit;
  delay_t delay_x_value, delay_y_value, delay_z_value;
  phy_word_t tx_phy0, rx_phy0;
  lpif_state_t ustrm_state, dstrm_state;
  lpif_protid_t ustrm_protid, dstrm_protid;
  lpif_data_t ustrm_data, dstrm_data;
  lpif_crc_t ustrm_crc, dstrm_crc;
  logic ustrm_dvalid, ustrm_crc_valid, ustrm_valid;
  logic dstrm_dvalid, dstrm_crc_valid, dstrm_valid;

  row_t rows [NROWS];
  int errors, checks, m_k, m_tx_cnt, m_rx_cnt;
  logic timed_out, m_tx_on, m_rx_on;
  phy_word_t exp_tx;
  link_word_t exp_rx;

  always #50 clk_wr = ~clk_wr;

  lpif_link_top #(.PERSISTENT_MARKER(1'b1)) u_dut (.*);

  //////////////////////////////////////////////////////////////////////
  // Reference model
  function automatic link_word_t pack_link();
    link_word_t l;
    l = '0;
    l[0] = ustrm_valid;
    l[1] = ustrm_crc_valid;
    l[5:2] = ustrm_crc;
    l[6] = ustrm_dvalid;
    l[70:7] = ustrm_data;
    l[72:71] = ustrm_protid;
    l[76:73] = ustrm_state;
    return l;
  endfunction

  // Payload bits skip strobe, spare and marker in ascending order
  function automatic phy_word_t place(link_word_t l, logic stb, logic mrk);
    phy_word_t w;
    int j;
    w = '0;
    j = 0;
    for (int p = 0; p < PHY_W; p++) begin
      if (p == PHY_STB_POS) w[p] = stb;
      else if (p == PHY_MRK_POS) w[p] = mrk;
      else if (p != PHY_SPARE_POS) begin
        w[p] = l[j];
        j++;
      end
    end
    return w;
  endfunction

  function automatic link_word_t gather(phy_word_t w);
    link_word_t l;
    int j;
    l = '0;
    j = 0;
    for (int p = 0; p < PHY_W; p++) begin
      if (p != PHY_STB_POS && p != PHY_SPARE_POS && p != PHY_MRK_POS) begin
        l[j] = w[p];
        j++;
      end
    end
    return l;
  endfunction

  // Edges of high samples needed before a side is online
  function automatic int up_edges(delay_t d);
    return (d == '0) ? 2 : int'(d) + 1;
  endfunction

  // Advance one clock edge with the inputs just driven
  task automatic update_model();
    logic stb;
    int period;
    period = (delay_y_value == '0) ? 1 : int'(delay_y_value);
    stb = m_tx_on && ((m_k % period) == 0 || tx_stb_userbit);
    exp_tx = m_tx_on ? place(pack_link(), stb, tx_mrk_userbit) : '0;
    m_k = m_tx_on ? m_k + 1 : 0;
    m_tx_cnt = tx_online ? m_tx_cnt + 1 : 0;
    m_tx_on = tx_online && (m_tx_on || m_tx_cnt >= up_edges(delay_z_value));
    m_rx_cnt = rx_online ? m_rx_cnt + 1 : 0;
    m_rx_on = rx_online && (m_rx_on || m_rx_cnt >= up_edges(delay_x_value));
    // Receive register plus combinational gate
    exp_rx = m_rx_on ? gather(rx_phy0) : '0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks
  task automatic check(string name, logic [79:0] got, logic [79:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic compare_outputs();
    check("tx_phy0", tx_phy0, exp_tx);
    check("dstrm_valid", dstrm_valid, exp_rx[0]);
    check("dstrm_crc_valid", dstrm_crc_valid, exp_rx[1]);
    check("dstrm_crc", dstrm_crc, exp_rx[5:2]);
    check("dstrm_dvalid", dstrm_dvalid, exp_rx[6]);
    check("dstrm_data", dstrm_data, exp_rx[70:7]);
    check("dstrm_protid", dstrm_protid, exp_rx[72:71]);
    check("dstrm_state", dstrm_state, exp_rx[76:73]);
  endtask

  // Check last edge, then drive the next beat on the falling edge
  task automatic run_cycle(input row_t r);
    logic [95:0] rnd;
    @(negedge clk_wr);
    compare_outputs();
    tx_online = r.tx_on;
    rx_online = r.rx_on;
    tx_mrk_userbit = r.mrk;
    tx_stb_userbit = r.stb;
    ustrm_state = r.state;
    rnd = {$urandom, $urandom, $urandom};
    ustrm_data = rnd[63:0];
    ustrm_protid = rnd[65:64];
    ustrm_crc = rnd[69:66];
    {ustrm_dvalid, ustrm_crc_valid, ustrm_valid} = rnd[72:70];
    rnd = {$urandom, $urandom, $urandom};
    rx_phy0 = rnd[79:0];
    if (r.rsv[0]) rx_phy0[PHY_STB_POS] = 1'b1;
    if (r.rsv[1]) rx_phy0[PHY_SPARE_POS] = 1'b1;
    if (r.rsv[2]) rx_phy0[PHY_MRK_POS] = 1'b1;
    update_model();
  endtask

  // Step until each side that the row raises shows traffic
  task automatic wait_link_up(input row_t r);
    int n;
    logic up;
    n = 0;
    up = 1'b0;
    while (!up && n < UP_TIMEOUT) begin
      run_cycle(r);
      up = (!r.tx_on || tx_phy0 != '0) &&
           (!r.rx_on || (|{dstrm_state, dstrm_protid, dstrm_data, dstrm_crc}));
      n++;
    end
    if (!up) begin
      timed_out = 1'b1;
      $display("Timeout: link did not come up within %0d cycles", UP_TIMEOUT);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus table
  task automatic load_table();
    // tx_on rx_on mrk stb rsv state cycles
    rows[0] = '{1'b0, 1'b0, 1'b1, 1'b1, 3'b111, 4'h9, 8'd4};
    rows[1] = '{1'b1, 1'b0, 1'b1, 1'b0, 3'b000, 4'h1, 8'd0};
    rows[2] = '{1'b1, 1'b0, 1'b1, 1'b0, 3'b000, 4'h2, 8'd9};
    rows[3] = '{1'b1, 1'b0, 1'b0, 1'b1, 3'b000, 4'h3, 8'd3};
    rows[4] = '{1'b1, 1'b1, 1'b0, 1'b0, 3'b101, 4'h4, 8'd0};
    rows[5] = '{1'b1, 1'b1, 1'b1, 1'b0, 3'b111, 4'h5, 8'd8};
    rows[6] = '{1'b0, 1'b1, 1'b0, 1'b0, 3'b010, 4'h6, 8'd3};
    rows[7] = '{1'b1, 1'b0, 1'b0, 1'b0, 3'b000, 4'h7, 8'd3};
    rows[8] = '{1'b1, 1'b1, 1'b0, 1'b0, 3'b000, 4'h8, 8'd0};
    rows[9] = '{1'b1, 1'b1, 1'b0, 1'b1, 3'b010, 4'hc, 8'd6};
  endtask

  initial begin
    void'($urandom(32'hbed1_a957));
    {tx_online, rx_online, tx_mrk_userbit, tx_stb_userbit} = '0;
    {ustrm_state, ustrm_protid, ustrm_data, ustrm_crc} = '0;
    {ustrm_dvalid, ustrm_crc_valid, ustrm_valid} = '0;
    rx_phy0 = '0;
    delay_x_value = 16'd3;
    delay_y_value = 16'd4;
    delay_z_value = 16'd5;
    rst_n = 1'b0;
    {errors, checks, m_k, m_tx_cnt, m_rx_cnt} = '0;
    {timed_out, m_tx_on, m_rx_on} = '0;
    exp_tx = '0;
    exp_rx = '0;
    load_table();
    repeat (10) @(negedge clk_wr);
    rst_n = 1'b1;
    for (int i = 0; i < NROWS && !timed_out; i++) begin
      if (rows[i].cycles == 8'd0) wait_link_up(rows[i]);
      else repeat (rows[i].cycles) run_cycle(rows[i]);
    end
    @(negedge clk_wr);
    compare_outputs();
    $display("Checks: %0d, errors: %0d, timeout: %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: files.f
hdl/lpif_pkg.sv
hdl/ll_auto_sync.sv
hdl/lpif_field_map.sv
hdl/lpif_phy_concat.sv
hdl/lpif_link_top.sv
testbench/tb_lpif_link.sv

// File: Makefile
# Verilator build and run for the LPIF link layer testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_lpif_link
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "test failed" $(LOG); then echo "FAIL"; exit 1; else echo "PASS"; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
